/* design/mulCore.sv */
`timescale 1ns/1ps
`default_nettype none

module mulCore (
	input logic clock,
	input logic reset,
	input logic issue,
	input logic isSigned,
	input mulPkg::word_t srcA,
	input mulPkg::word_t srcB,
	output mulPkg::dword_t product
);
	import mulPkg::*;

	// input register
	word_t aReg;
	word_t bReg;
	// signedness of the op in the input register
	logic signed0;

	// halves widened to 32 bits for the stage 1 multipliers
	word_t aLoExt;
	word_t aHiExt;
	word_t bLoExt;
	word_t bHiExt;

	// stage 1 partial products
	// LL is lo*lo, HH is hi*hi, LH and HL are the cross terms
	word_t mulLL;
	word_t mulLH;
	word_t mulHL;
	word_t mulHH;
	// signedness of the op in stage 1
	logic signed1;

	// cross terms placed at bit 16 and widened to 64 bits
	dword_t crossA;
	dword_t crossB;
	dword_t crossSum;

	// stage 2 state
	// lanes 0..1 hold LL, lanes 2..3 hold HH
	half_t lane [0:3];
	dword_t crossReg;

	// operand extension and the cross-product add
	always_comb
	begin
		// low halves are always unsigned
		aLoExt = {16'h0000, aReg[15:0]};
		bLoExt = {16'h0000, bReg[15:0]};
		// high halves carry the operand sign for signed ops
		aHiExt = {{16{signed0 & aReg[31]}}, aReg[31:16]};
		bHiExt = {{16{signed0 & bReg[31]}}, bReg[31:16]};

		// a signed cross term fits 32 bits, so its top bit is its sign
		crossA = {{16{signed1 & mulLH[31]}}, mulLH, 16'h0000};
		crossB = {{16{signed1 & mulHL[31]}}, mulHL, 16'h0000};
		// first of the two 64-bit adds
		crossSum = crossA + crossB;
	end

	// operands load only on issue
	always_ff @(posedge clock)
	begin
		if (issue)
		begin
			aReg <= srcA;
			bReg <= srcB;
		end
	end

	// signedness rides along with each op
	// so mixed signed and unsigned ops can go back to back
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			signed0 <= 1'b0;
			signed1 <= 1'b0;
		end
		else
		begin
			if (issue)
				signed0 <= isSigned;
			signed1 <= signed0;
		end
	end

	// stage 1
	// products truncated to 32 bits
	// exact here since the signed cases fit a signed 32-bit word
	always_ff @(posedge clock)
	begin
		mulLL <= aLoExt * bLoExt;
		mulLH <= aLoExt * bHiExt;
		mulHL <= aHiExt * bLoExt;
		mulHH <= aHiExt * bHiExt;
	end

	// stage 2
	// LL and HH are split into lanes, the cross terms are summed
	always_ff @(posedge clock)
	begin
		lane[0] <= mulLL[15:0];
		lane[1] <= mulLL[31:16];
		lane[2] <= mulHH[15:0];
		lane[3] <= mulHH[31:16];
		crossReg <= crossSum;
	end

	// stage 3
	// second 64-bit add, lane vector plus cross sum
	// HH sits in the top word, its sign bits past 63 drop off mod 2^64
	always_ff @(posedge clock)
	begin
		product <= {lane[3], lane[2], lane[1], lane[0]} + crossReg;
	end

endmodule

`default_nettype wire

/* design/mulOpDecode.sv */
`timescale 1ns/1ps
`default_nettype none

module mulOpDecode (
	input logic clock,
	input logic reset,
	input logic issue,
	input mulPkg::mulOp_t op,
	input mulPkg::regTag_t tag,
	output logic isSigned,
	output logic alignValid,
	output logic alignBad,
	output mulPkg::resSel_t alignSel,
	output logic alignSext,
	output mulPkg::regTag_t alignTag
);
	import mulPkg::*;

	// decoded fields of the current op
	logic opKnown;
	resSel_t opSel;
	logic opSext;

	// delay line, one entry per core stage plus the input register
	logic [CORE_LATENCY:0] validPipe;
	logic [CORE_LATENCY:0] badPipe;
	resSel_t selPipe [0:CORE_LATENCY];
	logic sextPipe [0:CORE_LATENCY];
	regTag_t tagPipe [0:CORE_LATENCY];

	// op decode into signedness, selection and code validity
	always_comb
	begin
		isSigned = 1'b0;
		opSel = SEL_WIDE;
		opSext = 1'b0;
		opKnown = 1'b1;
		case (op)
			MUL_LS:
			begin
				isSigned = 1'b1;
				opSel = SEL_LOW;
				opSext = 1'b1;
			end
			MUL_LU:
				opSel = SEL_LOW;
			MUL_HS:
			begin
				isSigned = 1'b1;
				opSel = SEL_HIGH;
				opSext = 1'b1;
			end
			MUL_HU:
				opSel = SEL_HIGH;
			MUL_WS:
				isSigned = 1'b1;
			MUL_WU:
				opSel = SEL_WIDE;
			// undefined code is flagged bad further down
			default:
				opKnown = 1'b0;
		endcase
	end

	// strobe delay line
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			validPipe <= '0;
			badPipe <= '0;
		end
		else
		begin
			validPipe <= {validPipe[CORE_LATENCY-1:0], issue & opKnown};
			badPipe <= {badPipe[CORE_LATENCY-1:0], issue & ~opKnown};
		end
	end

	// selection, extension and tag follow the strobes
	always_ff @(posedge clock)
	begin
		selPipe[0] <= opSel;
		sextPipe[0] <= opSext;
		tagPipe[0] <= tag;
		for (int i = 1; i <= CORE_LATENCY; i++)
		begin
			selPipe[i] <= selPipe[i-1];
			sextPipe[i] <= sextPipe[i-1];
			tagPipe[i] <= tagPipe[i-1];
		end
	end

	// last entry lines up with the core's product
	assign alignValid = validPipe[CORE_LATENCY];
	assign alignBad = badPipe[CORE_LATENCY];
	assign alignSel = selPipe[CORE_LATENCY];
	assign alignSext = sextPipe[CORE_LATENCY];
	assign alignTag = tagPipe[CORE_LATENCY];

endmodule

`default_nettype wire

/* design/mulPkg.sv */
`default_nettype none

// types and constants shared by the multiply unit blocks
package mulPkg;

	// operand word
	typedef logic [31:0] word_t;
	// full product or formatted result
	typedef logic [63:0] dword_t;
	// one 16-bit lane of a partial product
	typedef logic [15:0] half_t;
	// destination register tag, passed through untouched
	typedef logic [4:0] regTag_t;

	// operation codes
	// codes 6 and 7 are undefined and come back as opError
	typedef enum logic [2:0] {
		// signed, low word sign-extended
		MUL_LS = 3'd0,
		// unsigned, low word zero-extended
		MUL_LU = 3'd1,
		// signed, high word sign-extended
		MUL_HS = 3'd2,
		// unsigned, high word zero-extended
		MUL_HU = 3'd3,
		// signed, full 64 bits
		MUL_WS = 3'd4,
		// unsigned, full 64 bits
		MUL_WU = 3'd5
	} mulOp_t;

	// which part of the product the formatter returns
	typedef enum logic [1:0] {
		SEL_LOW  = 2'd0,
		SEL_HIGH = 2'd1,
		SEL_WIDE = 2'd2
	} resSel_t;

	// register stages in mulCore after its input register
	localparam int CORE_LATENCY = 3;

	// issue cycle to result cycle
	localparam int UNIT_LATENCY = 5;

endpackage

`default_nettype wire

/* design/mulResultFormat.sv */
`timescale 1ns/1ps
`default_nettype none

module mulResultFormat (
	input logic clock,
	input logic reset,
	input mulPkg::dword_t product,
	input logic alignValid,
	input logic alignBad,
	input mulPkg::resSel_t alignSel,
	input logic alignSext,
	input mulPkg::regTag_t alignTag,
	output logic resultValid,
	output logic opError,
	output mulPkg::dword_t result,
	output mulPkg::regTag_t resultTag
);
	import mulPkg::*;

	// product after selection and extension
	dword_t selected;

	// pick the word and extend it
	// alignSext says signed or zero extension
	always_comb
	begin
		case (alignSel)
			SEL_WIDE:
				selected = product;
			SEL_LOW:
				selected = {{32{alignSext & product[31]}}, product[31:0]};
			SEL_HIGH:
				selected = {{32{alignSext & product[63]}}, product[63:32]};
			// unused selection code
			default:
				selected = '0;
		endcase
	end

	// output register
	// result and tag hold their value between strobes
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			resultValid <= 1'b0;
			opError <= 1'b0;
			result <= '0;
			resultTag <= '0;
		end
		else
		begin
			resultValid <= alignValid;
			opError <= alignBad;
			if (alignValid | alignBad)
			begin
				// a bad op returns zero but keeps its tag
				result <= alignBad ? '0 : selected;
				resultTag <= alignTag;
			end
		end
	end

endmodule

`default_nettype wire

/* design/mulUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module mulUnit (
	input logic clock,
	input logic reset,
	input logic issue,
	input mulPkg::mulOp_t op,
	input mulPkg::word_t srcA,
	input mulPkg::word_t srcB,
	input mulPkg::regTag_t tag,
	output logic resultValid,
	output logic opError,
	output mulPkg::dword_t result,
	output mulPkg::regTag_t resultTag
);
	import mulPkg::*;

	// decoder to core, valid in the issue cycle
	logic isSigned;

	// decoder to formatter, aligned with the product
	logic alignValid;
	logic alignBad;
	resSel_t alignSel;
	logic alignSext;
	regTag_t alignTag;

	// core to formatter
	dword_t product;

	// op decode and control delay line
	mulOpDecode i_mulOpDecode (
		.clock(clock),
		.reset(reset),
		.issue(issue),
		.op(op),
		.tag(tag),
		.isSigned(isSigned),
		.alignValid(alignValid),
		.alignBad(alignBad),
		.alignSel(alignSel),
		.alignSext(alignSext),
		.alignTag(alignTag)
	);

	// pipelined 32x32 multiplier
	mulCore i_mulCore (
		.clock(clock),
		.reset(reset),
		.issue(issue),
		.isSigned(isSigned),
		.srcA(srcA),
		.srcB(srcB),
		.product(product)
	);

	// selection, extension and output strobes
	mulResultFormat i_mulResultFormat (
		.clock(clock),
		.reset(reset),
		.product(product),
		.alignValid(alignValid),
		.alignBad(alignBad),
		.alignSel(alignSel),
		.alignSext(alignSext),
		.alignTag(alignTag),
		.resultValid(resultValid),
		.opError(opError),
		.result(result),
		.resultTag(resultTag)
	);

endmodule

`default_nettype wire

/* mulUnit.f */
design/mulPkg.sv
design/mulOpDecode.sv
design/mulCore.sv
design/mulResultFormat.sv
design/mulUnit.sv
verification/mulUnit_assert.sv
verification/mulUnitTb.sv

/* runSim.sh */
#!/bin/sh
# compile and run the multiply unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module mulUnitTb -f mulUnit.f -o mulUnitSim

# a failing run is judged by the missing pass line below
output=$(./obj_dir/mulUnitSim 2>&1 || true)
echo "$output"

if echo "$output" | grep -q "^Regression passed$"; then
	exit 0
fi
exit 1

/* verification/mulUnitTb.sv */
`timescale 1ns/1ps
`default_nettype none

module mulUnitTb;
	import mulPkg::*;

	// eight op codes times five by five corner operands, then random rows
	localparam int CORNER_ROWS = 8 * 5 * 5;
	localparam int RANDOM_ROWS = 20;
	localparam int NUM_ROWS = CORNER_ROWS + RANDOM_ROWS;
	localparam int WATCHDOG_NS = (NUM_ROWS + UNIT_LATENCY + 20) * 100;

	logic clock;
	logic reset;
	logic issue;
	mulOp_t op;
	word_t srcA;
	word_t srcB;
	regTag_t tag;
	logic resultValid;
	logic opError;
	dword_t result;
	regTag_t resultTag;

	// stimulus and expected values with one entry per test
	string rowName [NUM_ROWS];
	logic [2:0] rowOp [NUM_ROWS];
	word_t rowA [NUM_ROWS];
	word_t rowB [NUM_ROWS];
	regTag_t rowTag [NUM_ROWS];
	dword_t rowExp [NUM_ROWS];
	// low means an undefined code, so opError is expected instead
	logic rowExpValid [NUM_ROWS];

	logic [31:0] lfsrState;
	int errorCount = 0;
	int testsFailed = 0;
	logic rowBad;

	mulUnit i_mulUnit (
		.clock(clock),
		.reset(reset),
		.issue(issue),
		.op(op),
		.srcA(srcA),
		.srcB(srcB),
		.tag(tag),
		.resultValid(resultValid),
		.opError(opError),
		.result(result),
		.resultTag(resultTag)
	);

	always #50 clock = ~clock;

	// galois lfsr over x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] state);
		if (state[0])
			return (state >> 1) ^ 32'h80200003;
		return state >> 1;
	endfunction

	// msb first with one lfsr step per bit
	function automatic logic [31:0] takeBits(input int count);
		logic [31:0] bits;
		bits = '0;
		for (int k = 0; k < count; k++)
		begin
			bits = {bits[30:0], lfsrState[0]};
			lfsrState = lfsrNext(lfsrState);
		end
		return bits;
	endfunction

	// exact 64-bit product, then the op's selection rule
	function automatic dword_t expectedResult(input logic [2:0] code, input word_t a,
		input word_t b);
		dword_t wide;
		dword_t aWide;
		dword_t bWide;
		logic signedOp;
		signedOp = (code == MUL_LS) || (code == MUL_HS) || (code == MUL_WS);
		aWide = signedOp ? {{32{a[31]}}, a} : {32'h0, a};
		bWide = signedOp ? {{32{b[31]}}, b} : {32'h0, b};
		// mod 2^64 this is the two's-complement product too
		wide = aWide * bWide;
		case (code)
			MUL_LS: return {{32{wide[31]}}, wide[31:0]};
			MUL_LU: return {32'h0, wide[31:0]};
			MUL_HS: return {{32{wide[63]}}, wide[63:32]};
			MUL_HU: return {32'h0, wide[63:32]};
			MUL_WS, MUL_WU: return wide;
			default: return '0;
		endcase
	endfunction

	function automatic void setRow(input int idx, input logic [2:0] code, input word_t a,
		input word_t b, input regTag_t t, input string name);
		rowName[idx] = name;
		rowOp[idx] = code;
		rowA[idx] = a;
		rowB[idx] = b;
		rowTag[idx] = t;
		rowExp[idx] = expectedResult(code, a, b);
		rowExpValid[idx] = (code <= 3'd5);
	endfunction

	function automatic void buildTable();
		word_t corner [5];
		int idx;
		logic [31:0] opBits;
		logic [31:0] aBits;
		logic [31:0] bBits;
		logic [31:0] tagBits;
		corner = '{32'h0, 32'h1, 32'hffffffff, 32'h80000000, 32'h7fffffff};
		idx = 0;
		// every code, the two undefined ones too
		for (int code = 0; code < 8; code++)
			for (int ia = 0; ia < 5; ia++)
				for (int ib = 0; ib < 5; ib++)
				begin
					setRow(idx, code[2:0], corner[ia], corner[ib], idx[4:0],
						$sformatf("corner op%0d a=%h b=%h", code, corner[ia], corner[ib]));
					idx++;
				end
		lfsrState = 32'h3dec913b;
		for (int k = 0; k < RANDOM_ROWS; k++)
		begin
			opBits = takeBits(3);
			aBits = takeBits(32);
			bBits = takeBits(32);
			tagBits = takeBits(5);
			setRow(idx, opBits[2:0], aBits, bBits, tagBits[4:0],
				$sformatf("random%0d op%0d", k, opBits[2:0]));
			idx++;
		end
	endfunction

	task automatic checkWord(input string name, input dword_t expected, input dword_t actual);
		if (actual !== expected)
		begin
			$display("FAIL %s result: expected %h, actual %h", name, expected, actual);
			errorCount++;
			rowBad = 1'b1;
		end
	endtask

	task automatic checkTag(input string name, input regTag_t expected,
		input regTag_t actual);
		if (actual !== expected)
		begin
			$display("FAIL %s resultTag: expected %h, actual %h", name, expected, actual);
			errorCount++;
			rowBad = 1'b1;
		end
	endtask

	task automatic checkStrobe(input string name, input string which, input logic expected,
		input logic actual);
		if (actual !== expected)
		begin
			$display("FAIL %s %s: expected %b, actual %b", name, which, expected, actual);
			errorCount++;
			rowBad = 1'b1;
		end
	endtask

	task automatic checkRow(input int i);
		rowBad = 1'b0;
		checkStrobe(rowName[i], "resultValid", rowExpValid[i], resultValid);
		checkStrobe(rowName[i], "opError", !rowExpValid[i], opError);
		checkWord(rowName[i], rowExp[i], result);
		checkTag(rowName[i], rowTag[i], resultTag);
		if (rowBad)
			testsFailed++;
		else
			$display("PASS %s", rowName[i]);
	endtask

	initial
	begin
		clock = 1'b0;
		reset = 1'b1;
		// a valid op is offered on every reset cycle and must never come out
		issue = 1'b1;
		op = MUL_WU;
		srcA = 32'h12345678;
		srcB = 32'h9abcdef0;
		tag = 5'h1f;
		buildTable();

		// strobes low while reset is held, then for two cycles after it
		repeat (10)
		begin
			@(negedge clock);
			checkStrobe("reset", "resultValid", 1'b0, resultValid);
			checkStrobe("reset", "opError", 1'b0, opError);
		end
		reset = 1'b0;
		issue = 1'b0;
		repeat (2)
		begin
			@(negedge clock);
			checkStrobe("reset", "resultValid", 1'b0, resultValid);
			checkStrobe("reset", "opError", 1'b0, opError);
			checkWord("reset", '0, result);
			checkTag("reset", '0, resultTag);
		end
		if (errorCount == 0)
			$display("PASS reset");

		// rows go in back to back and each result is due UNIT_LATENCY cycles later
		fork
			begin
				for (int i = 0; i < NUM_ROWS; i++)
				begin
					issue = 1'b1;
					op = mulOp_t'(rowOp[i]);
					srcA = rowA[i];
					srcB = rowB[i];
					tag = rowTag[i];
					@(negedge clock);
				end
				issue = 1'b0;
			end
			begin
				repeat (UNIT_LATENCY) @(negedge clock);
				for (int i = 0; i < NUM_ROWS; i++)
				begin
					checkRow(i);
					@(negedge clock);
				end
			end
		join

		// nothing in flight any more
		repeat (3)
		begin
			checkStrobe("idle", "resultValid", 1'b0, resultValid);
			checkStrobe("idle", "opError", 1'b0, opError);
			@(negedge clock);
		end

		$display("%0d tests, %0d failed, %0d check errors", NUM_ROWS, testsFailed, errorCount);
		if (errorCount == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	// watchdog
	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

/* verification/mulUnit_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module mulUnit_assert (
	input logic clock,
	input logic reset,
	input logic issue,
	input mulPkg::regTag_t tag,
	input logic resultValid,
	input logic opError,
	input mulPkg::dword_t result,
	input mulPkg::regTag_t resultTag
);
	import mulPkg::*;

	// the edge after a reset edge shows cleared outputs
	assert property (@(posedge clock) reset |=> (!resultValid && !opError && result == '0))
		else $error("outputs not cleared by reset");

	// result and error strobes are exclusive
	assert property (@(posedge clock) disable iff (reset) !(resultValid && opError))
		else $error("resultValid and opError high together");

	// each issue taken out of reset gives one strobe UNIT_LATENCY cycles later
	assert property (@(posedge clock) disable iff (reset)
		(resultValid || opError) == $past(issue && !reset, UNIT_LATENCY))
		else $error("strobe does not match an issue UNIT_LATENCY cycles earlier");

	// tag comes back unchanged
	assert property (@(posedge clock) disable iff (reset)
		(resultValid || opError) |-> (resultTag == $past(tag, UNIT_LATENCY)))
		else $error("resultTag differs from the issued tag");

endmodule

bind mulUnit mulUnit_assert i_mulUnitAssert (
	.clock(clock),
	.reset(reset),
	.issue(issue),
	.tag(tag),
	.resultValid(resultValid),
	.opError(opError),
	.result(result),
	.resultTag(resultTag)
);

`default_nettype wire
